/* source/tx_mix_pkg.sv */
package tx_mix_pkg;

    // ----------------------------------------------------------
    // channel count and datapath widths
    // ----------------------------------------------------------
    localparam int NUM_CH     = 5;
    localparam int SAMPLE_W   = 16;
    // unsigned gain word, q2.30
    localparam int GAIN_W     = 32;
    localparam int GAIN_SHIFT = 30;
    // signed sample times zero-extended gain
    localparam int PROD_W     = SAMPLE_W + GAIN_W + 1;
    // five 16-bit inputs need three bits of growth
    localparam int SUM_W      = 19;
    localparam int DAC_W      = 14;
    localparam int SHIFT_W    = 3;

    // ----------------------------------------------------------
    // capture buffers
    // ----------------------------------------------------------
    localparam int CAP_IDX_W  = 16;
    localparam int LS_DEPTH   = 64;
    localparam int HS_DEPTH   = 256;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [GAIN_W-1:0] gain_t;
    typedef logic [DAC_W-1:0] dac_code_t;

    // upsampler source, codes 2 and 3 fall back to gained data
    typedef enum logic [1:0] {
        UP_GAINED = 2'd0,
        UP_CPU    = 2'd1
    } up_src_e;

    // dac source, codes above SRC_SUM fall back to the sum
    typedef enum logic [3:0] {
        SRC_GAIN_Y0 = 4'd0,
        SRC_GAIN_Y1 = 4'd1,
        SRC_GAIN_Y2 = 4'd2,
        SRC_GAIN_Y3 = 4'd3,
        SRC_GAIN_Y4 = 4'd4,
        SRC_TX0     = 4'd5,
        SRC_TX1     = 4'd6,
        SRC_TX2     = 4'd7,
        SRC_TX3     = 4'd8,
        SRC_TX4     = 4'd9,
        SRC_SUM     = 4'd10
    } dac_src_e;

endpackage

/* source/cap_if.sv */
`timescale 1ns/1ps

interface cap_if;

    import tx_mix_pkg::*;

    // rising edge starts a capture
    logic              arm;
    // readback address, low bits only
    logic [CAP_IDX_W-1:0] idx;
    // high once the buffer is full
    logic              done;
    // entry at idx, no read latency
    sample_t           data;

    // csr side
    modport ctrl (output arm, output idx, input done, input data);

    // buffer side
    modport engine (input arm, input idx, output done, output data);

endinterface

/* source/channel_gain.sv */
`timescale 1ns/1ps

module channel_gain (
    input  logic                  sys_clk,
    input  logic                  rst,
    input  logic                  i_ce_down,
    input  tx_mix_pkg::sample_t   i_down_x,
    input  tx_mix_pkg::sample_t   i_down_y,
    input  tx_mix_pkg::sample_t   i_cpu_x,
    input  tx_mix_pkg::sample_t   i_cpu_y,
    input  tx_mix_pkg::gain_t     i_gain,
    input  tx_mix_pkg::up_src_e   i_up_src,
    output tx_mix_pkg::sample_t   o_gained_y,
    output tx_mix_pkg::sample_t   o_up_x,
    output tx_mix_pkg::sample_t   o_up_y
);

    import tx_mix_pkg::*;

    // gain is unsigned, so prepend a zero before the signed multiply
    logic signed [GAIN_W:0]   gain_s;
    logic signed [PROD_W-1:0] prod_x;
    logic signed [PROD_W-1:0] prod_y;
    sample_t                  gained_x;
    sample_t                  gained_y;

    assign gain_s = {1'b0, i_gain};
    assign prod_x = PROD_W'(i_down_x) * PROD_W'(gain_s);
    assign prod_y = PROD_W'(i_down_y) * PROD_W'(gain_s);

    // ----------------------------------------------------------
    // decimated-rate gain register
    // ----------------------------------------------------------
    // >>> 30 then keep low 16 bits, same as taking bits 45:30
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            gained_x <= '0;
            gained_y <= '0;
        end else if (i_ce_down) begin
            gained_x <= prod_x[GAIN_SHIFT +: SAMPLE_W];
            gained_y <= prod_y[GAIN_SHIFT +: SAMPLE_W];
        end
    end

    assign o_gained_y = gained_y;

    // upsampler feed, cpu pair or gained pair
    assign o_up_x = (i_up_src == UP_CPU) ? i_cpu_x : gained_x;
    assign o_up_y = (i_up_src == UP_CPU) ? i_cpu_y : gained_y;

endmodule

/* source/sum_tree.sv */
`timescale 1ns/1ps

module sum_tree (
    input  logic                                  sys_clk,
    input  logic                                  rst,
    input  tx_mix_pkg::sample_t                   i_tx_in [tx_mix_pkg::NUM_CH],
    input  logic [tx_mix_pkg::SHIFT_W-1:0]        i_final_shift,
    output logic signed [tx_mix_pkg::SUM_W-1:0]   o_sum_full,
    output tx_mix_pkg::dac_code_t                 o_sum_trunc,
    output tx_mix_pkg::dac_code_t                 o_sum
);

    import tx_mix_pkg::*;

    // stage 1, 17 bits
    logic signed [SAMPLE_W:0]   s1_a;
    logic signed [SAMPLE_W:0]   s1_b;
    logic signed [SAMPLE_W:0]   s1_c;
    // stage 2, 18 bits
    logic signed [SAMPLE_W+1:0] s2_ab;
    logic signed [SAMPLE_W+1:0] s2_c;
    // stage 3, full 19-bit sum
    logic signed [SUM_W-1:0]    s3_sum;
    // stage 4, top 14 bits of the sum
    dac_code_t                  sum_trunc;

    // ----------------------------------------------------------
    // balanced adder pipeline
    // ----------------------------------------------------------
    // every operand is sign extended by one bit before the add
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            s1_a      <= '0;
            s1_b      <= '0;
            s1_c      <= '0;
            s2_ab     <= '0;
            s2_c      <= '0;
            s3_sum    <= '0;
            sum_trunc <= '0;
        end else begin
            // pairs 0+1 and 2+3, channel 4 rides along
            s1_a   <= {i_tx_in[0][SAMPLE_W-1], i_tx_in[0]}
                    + {i_tx_in[1][SAMPLE_W-1], i_tx_in[1]};
            s1_b   <= {i_tx_in[2][SAMPLE_W-1], i_tx_in[2]}
                    + {i_tx_in[3][SAMPLE_W-1], i_tx_in[3]};
            s1_c   <= {i_tx_in[4][SAMPLE_W-1], i_tx_in[4]};

            s2_ab  <= {s1_a[SAMPLE_W], s1_a} + {s1_b[SAMPLE_W], s1_b};
            s2_c   <= {s1_c[SAMPLE_W], s1_c};

            s3_sum <= {s2_ab[SAMPLE_W+1], s2_ab} + {s2_c[SAMPLE_W+1], s2_c};

            // drop the 5 lsbs, no rounding
            sum_trunc <= s3_sum[SUM_W-1 -: DAC_W];
        end
    end

    assign o_sum_full  = s3_sum;
    assign o_sum_trunc = sum_trunc;

    // final gain-up, bits shifted past the msb are lost
    assign o_sum = sum_trunc << i_final_shift;

endmodule

/* source/dac_route.sv */
`timescale 1ns/1ps

module dac_route (
    input  logic                                  sys_clk,
    input  logic                                  rst,
    input  tx_mix_pkg::dac_src_e                  i_sel,
    input  tx_mix_pkg::sample_t                   i_gained_y [tx_mix_pkg::NUM_CH],
    input  tx_mix_pkg::sample_t                   i_tx_in [tx_mix_pkg::NUM_CH],
    input  logic signed [tx_mix_pkg::SUM_W-1:0]   i_sum_full,
    output tx_mix_pkg::dac_code_t                 o_dac
);

    import tx_mix_pkg::*;

    // two's complement code before the offset
    dac_code_t src_code;

    // ----------------------------------------------------------
    // source select, top 14 bits of each source
    // ----------------------------------------------------------
    always_comb begin
        case (i_sel)
            SRC_GAIN_Y0: src_code = i_gained_y[0][SAMPLE_W-1 -: DAC_W];
            SRC_GAIN_Y1: src_code = i_gained_y[1][SAMPLE_W-1 -: DAC_W];
            SRC_GAIN_Y2: src_code = i_gained_y[2][SAMPLE_W-1 -: DAC_W];
            SRC_GAIN_Y3: src_code = i_gained_y[3][SAMPLE_W-1 -: DAC_W];
            SRC_GAIN_Y4: src_code = i_gained_y[4][SAMPLE_W-1 -: DAC_W];
            SRC_TX0:     src_code = i_tx_in[0][SAMPLE_W-1 -: DAC_W];
            SRC_TX1:     src_code = i_tx_in[1][SAMPLE_W-1 -: DAC_W];
            SRC_TX2:     src_code = i_tx_in[2][SAMPLE_W-1 -: DAC_W];
            SRC_TX3:     src_code = i_tx_in[3][SAMPLE_W-1 -: DAC_W];
            SRC_TX4:     src_code = i_tx_in[4][SAMPLE_W-1 -: DAC_W];
            // sum and any unlisted code
            default:     src_code = i_sum_full[SUM_W-1 -: DAC_W];
        endcase
    end

    // ----------------------------------------------------------
    // offset-binary register
    // ----------------------------------------------------------
    // flipping the msb is the +8192 offset, midscale = 0x2000
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_dac <= '0;
        end else begin
            o_dac <= {~src_code[DAC_W-1], src_code[DAC_W-2:0]};
        end
    end

endmodule

/* source/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture #(
    parameter int DEPTH   = tx_mix_pkg::LS_DEPTH,
    // set when writes wait for the strobe
    parameter bit STROBED = 1'b1
) (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 i_ce_down,
    input  tx_mix_pkg::sample_t  i_sample,
    cap_if.engine                cap
);

    import tx_mix_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    // arm edge detect
    logic             arm_q;
    logic             arm_edge;
    // capture state
    logic             capturing;
    logic             done_q;
    logic [PTR_W-1:0] wr_ptr;
    logic             wr_en;
    logic             last_wr;
    // sample storage
    sample_t          mem [DEPTH];

    assign arm_edge = cap.arm & ~arm_q;

    // strobe gating only in the low-speed build
    assign wr_en   = capturing & (~STROBED | i_ce_down);
    assign last_wr = (wr_ptr == PTR_W'(DEPTH - 1));

    // ----------------------------------------------------------
    // capture control
    // ----------------------------------------------------------
    // an arm edge restarts from entry 0
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            arm_q     <= 1'b0;
            capturing <= 1'b0;
            done_q    <= 1'b0;
            wr_ptr    <= '0;
        end else begin
            arm_q <= cap.arm;
            if (arm_edge) begin
                capturing <= 1'b1;
                done_q    <= 1'b0;
                wr_ptr    <= '0;
            end else if (wr_en) begin
                // last entry closes the capture
                if (last_wr) begin
                    capturing <= 1'b0;
                    done_q    <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + PTR_W'(1);
                end
            end
        end
    end

    // ----------------------------------------------------------
    // buffer write
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_sample;
        end
    end

    assign cap.done = done_q;

    // async readback on the low idx bits only
    assign cap.data = mem[cap.idx[PTR_W-1:0]];

endmodule

/* source/tx_mix_top.sv */
`timescale 1ns/1ps

module tx_mix_top (
    input  logic                                 sys_clk,
    input  logic                                 rst,
    input  logic                                 i_ce_down,
    // decimated i/q from the receive side
    input  tx_mix_pkg::sample_t                  i_down_x [tx_mix_pkg::NUM_CH],
    input  tx_mix_pkg::sample_t                  i_down_y [tx_mix_pkg::NUM_CH],
    // cpu-supplied upsampler pair, shared by all channels
    input  tx_mix_pkg::sample_t                  i_cpu_x,
    input  tx_mix_pkg::sample_t                  i_cpu_y,
    input  tx_mix_pkg::gain_t                    i_gain [tx_mix_pkg::NUM_CH],
    input  tx_mix_pkg::up_src_e                  i_up_src,
    // tx channel outputs
    input  tx_mix_pkg::sample_t                  i_tx_in [tx_mix_pkg::NUM_CH],
    input  logic [tx_mix_pkg::SHIFT_W-1:0]       i_final_shift,
    input  tx_mix_pkg::dac_src_e                 i_dac1_sel,
    input  tx_mix_pkg::dac_src_e                 i_dac2_sel,
    // capture csr side
    input  logic                                 i_ls_arm,
    input  logic                                 i_hs_arm,
    input  logic [tx_mix_pkg::CAP_IDX_W-1:0]     i_ls_idx,
    input  logic [tx_mix_pkg::CAP_IDX_W-1:0]     i_hs_idx,
    output tx_mix_pkg::sample_t                  o_up_x [tx_mix_pkg::NUM_CH],
    output tx_mix_pkg::sample_t                  o_up_y [tx_mix_pkg::NUM_CH],
    output tx_mix_pkg::dac_code_t                o_sum,
    output tx_mix_pkg::dac_code_t                o_dac1,
    output tx_mix_pkg::dac_code_t                o_dac2,
    output logic                                 o_ls_done,
    output logic                                 o_hs_done,
    output tx_mix_pkg::sample_t                  o_ls_data,
    output tx_mix_pkg::sample_t                  o_hs_data
);

    import tx_mix_pkg::*;

    sample_t                  gained_y [NUM_CH];
    logic signed [SUM_W-1:0]  sum_full;
    dac_code_t                sum_trunc;
    // truncated sum widened for the high-speed buffer
    sample_t                  hs_sample;

    cap_if ls_cap ();
    cap_if hs_cap ();

    // ----------------------------------------------------------
    // per-channel gain and upsampler select
    // ----------------------------------------------------------
    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        channel_gain u_gain (
            .sys_clk    (sys_clk),
            .rst        (rst),
            .i_ce_down  (i_ce_down),
            .i_down_x   (i_down_x[g]),
            .i_down_y   (i_down_y[g]),
            .i_cpu_x    (i_cpu_x),
            .i_cpu_y    (i_cpu_y),
            .i_gain     (i_gain[g]),
            .i_up_src   (i_up_src),
            .o_gained_y (gained_y[g]),
            .o_up_x     (o_up_x[g]),
            .o_up_y     (o_up_y[g])
        );
    end

    // ----------------------------------------------------------
    // combiner
    // ----------------------------------------------------------
    sum_tree u_sum (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_tx_in       (i_tx_in),
        .i_final_shift (i_final_shift),
        .o_sum_full    (sum_full),
        .o_sum_trunc   (sum_trunc),
        .o_sum         (o_sum)
    );

    // two converter channels, same routing
    dac_route u_dac1 (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .i_sel      (i_dac1_sel),
        .i_gained_y (gained_y),
        .i_tx_in    (i_tx_in),
        .i_sum_full (sum_full),
        .o_dac      (o_dac1)
    );

    dac_route u_dac2 (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .i_sel      (i_dac2_sel),
        .i_gained_y (gained_y),
        .i_tx_in    (i_tx_in),
        .i_sum_full (sum_full),
        .o_dac      (o_dac2)
    );

    // ----------------------------------------------------------
    // debug capture
    // ----------------------------------------------------------
    assign ls_cap.arm = i_ls_arm;
    assign ls_cap.idx = i_ls_idx;
    assign o_ls_done  = ls_cap.done;
    assign o_ls_data  = ls_cap.data;

    assign hs_cap.arm = i_hs_arm;
    assign hs_cap.idx = i_hs_idx;
    assign o_hs_done  = hs_cap.done;
    assign o_hs_data  = hs_cap.data;

    assign hs_sample = {{(SAMPLE_W - DAC_W){sum_trunc[DAC_W-1]}}, sum_trunc};

    // low speed, gained y of channel 0 per strobe
    sample_capture #(
        .DEPTH   (LS_DEPTH),
        .STROBED (1'b1)
    ) u_ls_cap (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .i_ce_down (i_ce_down),
        .i_sample  (gained_y[0]),
        .cap       (ls_cap)
    );

    // high speed, truncated sum every cycle
    sample_capture #(
        .DEPTH   (HS_DEPTH),
        .STROBED (1'b0)
    ) u_hs_cap (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .i_ce_down (i_ce_down),
        .i_sample  (hs_sample),
        .cap       (hs_cap)
    );

endmodule

/* testbench/tb_tx_mix_top.sv */
`timescale 1ns/1ps

module tb_tx_mix_top;

    import tx_mix_pkg::*;

    // three capture passes of about 530 cycles each
    localparam int MAX_CYCLES = 5000;
    localparam int LS_AW      = $clog2(LS_DEPTH);
    localparam int HS_AW      = $clog2(HS_DEPTH);

    // dut inputs
    logic                   sys_clk;
    logic                   rst;
    logic                   ce_down;
    sample_t                down_x [NUM_CH];
    sample_t                down_y [NUM_CH];
    sample_t                cpu_x;
    sample_t                cpu_y;
    gain_t                  gain [NUM_CH];
    up_src_e                up_src;
    sample_t                tx_in [NUM_CH];
    logic [SHIFT_W-1:0]     final_shift;
    dac_src_e               dac1_sel;
    dac_src_e               dac2_sel;
    logic                   ls_arm;
    logic                   hs_arm;
    logic [CAP_IDX_W-1:0]   ls_idx;
    logic [CAP_IDX_W-1:0]   hs_idx;
    // dut outputs
    sample_t                o_up_x [NUM_CH];
    sample_t                o_up_y [NUM_CH];
    dac_code_t              o_sum;
    dac_code_t              o_dac1;
    dac_code_t              o_dac2;
    logic                   o_ls_done;
    logic                   o_hs_done;
    sample_t                o_ls_data;
    sample_t                o_hs_data;

    // ----------------------------------------------------------
    // reference model state
    // ----------------------------------------------------------
    sample_t                m_gx [NUM_CH];
    sample_t                m_gy [NUM_CH];
    // raw 19-bit sums
    // entry 3 lines up with the truncation reg
    logic signed [SUM_W-1:0] sum_hist [4];
    dac_code_t              m_dac1;
    dac_code_t              m_dac2;
    dac_code_t              exp_sum;
    sample_t                hs_expect;
    // capture buffer copies
    logic                   ls_arm_q;
    logic                   ls_on;
    logic                   ls_done;
    int                     ls_n;
    sample_t                ls_mem [LS_DEPTH];
    logic                   hs_arm_q;
    logic                   hs_on;
    logic                   hs_done;
    int                     hs_n;
    sample_t                hs_mem [HS_DEPTH];

    logic [31:0]            rng_state = 32'h507a_6ae4;
    int                     cycle_cnt = 0;

    tx_mix_top uut (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_ce_down     (ce_down),
        .i_down_x      (down_x),
        .i_down_y      (down_y),
        .i_cpu_x       (cpu_x),
        .i_cpu_y       (cpu_y),
        .i_gain        (gain),
        .i_up_src      (up_src),
        .i_tx_in       (tx_in),
        .i_final_shift (final_shift),
        .i_dac1_sel    (dac1_sel),
        .i_dac2_sel    (dac2_sel),
        .i_ls_arm      (ls_arm),
        .i_hs_arm      (hs_arm),
        .i_ls_idx      (ls_idx),
        .i_hs_idx      (hs_idx),
        .o_up_x        (o_up_x),
        .o_up_y        (o_up_y),
        .o_sum         (o_sum),
        .o_dac1        (o_dac1),
        .o_dac2        (o_dac2),
        .o_ls_done     (o_ls_done),
        .o_hs_done     (o_hs_done),
        .o_ls_data     (o_ls_data),
        .o_hs_data     (o_hs_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first mismatch");
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // signed sample times unsigned gain then >>> 30 into 16 bits
    function automatic sample_t scale_sample(input sample_t s, input gain_t g);
        longint prod;
        prod = longint'(s) * longint'({32'd0, g});
        return sample_t'(prod >>> GAIN_SHIFT);
    endfunction

    function automatic logic signed [SUM_W-1:0] sum_inputs();
        logic signed [SUM_W-1:0] acc;
        acc = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            acc = acc + SUM_W'(tx_in[c]);
        end
        return acc;
    endfunction

    // top 14 bits of the chosen source with the msb flipped
    function automatic dac_code_t dac_expect(input dac_src_e sel);
        dac_code_t code;
        int        k;
        k = int'(sel);
        if (k < 5) begin
            code = m_gy[k][SAMPLE_W-1 -: DAC_W];
        end else if (k < 10) begin
            code = tx_in[k-5][SAMPLE_W-1 -: DAC_W];
        end else begin
            code = sum_hist[2][SUM_W-1 -: DAC_W];
        end
        return {~code[DAC_W-1], code[DAC_W-2:0]};
    endfunction

    assign exp_sum   = dac_code_t'(sum_hist[3][SUM_W-1 -: DAC_W] << final_shift);
    assign hs_expect = {{(SAMPLE_W-DAC_W){sum_hist[3][SUM_W-1]}},
                        sum_hist[3][SUM_W-1 -: DAC_W]};

    // gain regs, sum pipeline and dac regs
    always @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                m_gx[c] <= '0;
                m_gy[c] <= '0;
            end
            for (int k = 0; k < 4; k++) begin
                sum_hist[k] <= '0;
            end
            m_dac1 <= '0;
            m_dac2 <= '0;
        end else begin
            if (ce_down) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    m_gx[c] <= scale_sample(down_x[c], gain[c]);
                    m_gy[c] <= scale_sample(down_y[c], gain[c]);
                end
            end
            sum_hist[0] <= sum_inputs();
            for (int k = 1; k < 4; k++) begin
                sum_hist[k] <= sum_hist[k-1];
            end
            m_dac1 <= dac_expect(dac1_sel);
            m_dac2 <= dac_expect(dac2_sel);
        end
    end

    // ----------------------------------------------------------
    // capture model
    // ----------------------------------------------------------
    // an arm edge restarts at entry 0
    always @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            ls_arm_q <= 1'b0;
            ls_on    <= 1'b0;
            ls_done  <= 1'b0;
            ls_n     <= 0;
            hs_arm_q <= 1'b0;
            hs_on    <= 1'b0;
            hs_done  <= 1'b0;
            hs_n     <= 0;
        end else begin
            ls_arm_q <= ls_arm;
            hs_arm_q <= hs_arm;
            if (ls_arm && !ls_arm_q) begin
                ls_on   <= 1'b1;
                ls_done <= 1'b0;
                ls_n    <= 0;
            end else if (ls_on && ce_down) begin
                // value held at the strobe is the last strobe's result
                ls_mem[ls_n] <= m_gy[0];
                if (ls_n == LS_DEPTH - 1) begin
                    ls_on   <= 1'b0;
                    ls_done <= 1'b1;
                end else begin
                    ls_n <= ls_n + 1;
                end
            end
            if (hs_arm && !hs_arm_q) begin
                hs_on   <= 1'b1;
                hs_done <= 1'b0;
                hs_n    <= 0;
            end else if (hs_on) begin
                hs_mem[hs_n] <= hs_expect;
                if (hs_n == HS_DEPTH - 1) begin
                    hs_on   <= 1'b0;
                    hs_done <= 1'b1;
                end else begin
                    hs_n <= hs_n + 1;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // checks against the model on pre-edge values
    // ----------------------------------------------------------
    for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
        a_up_x: assert property (@(posedge sys_clk) disable iff (rst)
            o_up_x[c] == ((up_src == UP_CPU) ? cpu_x : m_gx[c]))
            else report_error($sformatf("o_up_x[%0d] differs from model", c));
        a_up_y: assert property (@(posedge sys_clk) disable iff (rst)
            o_up_y[c] == ((up_src == UP_CPU) ? cpu_y : m_gy[c]))
            else report_error($sformatf("o_up_y[%0d] differs from model", c));
    end

    a_sum: assert property (@(posedge sys_clk) disable iff (rst) o_sum == exp_sum)
        else report_error("o_sum differs from model");
    a_dac1: assert property (@(posedge sys_clk) disable iff (rst) o_dac1 == m_dac1)
        else report_error("o_dac1 differs from model");
    a_dac2: assert property (@(posedge sys_clk) disable iff (rst) o_dac2 == m_dac2)
        else report_error("o_dac2 differs from model");
    a_ls_done: assert property (@(posedge sys_clk) disable iff (rst) o_ls_done == ls_done)
        else report_error("o_ls_done differs from model");
    a_hs_done: assert property (@(posedge sys_clk) disable iff (rst) o_hs_done == hs_done)
        else report_error("o_hs_done differs from model");
    // readback only meaningful once the buffer is full
    a_ls_data: assert property (@(posedge sys_clk) disable iff (rst)
        ls_done |-> o_ls_data == ls_mem[ls_idx[LS_AW-1:0]])
        else report_error("o_ls_data differs from captured value");
    a_hs_data: assert property (@(posedge sys_clk) disable iff (rst)
        hs_done |-> o_hs_data == hs_mem[hs_idx[HS_AW-1:0]])
        else report_error("o_hs_data differs from captured value");

    // run limit
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: test still running after %0d clock cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "run limit reached");
        end
    end

    // new random data on every falling edge
    // arm and idx are left alone
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge sys_clk);
        for (int c = 0; c < NUM_CH; c++) begin
            r = lcg_next();
            down_x[c] = r[31:16];
            r = lcg_next();
            down_y[c] = r[31:16];
            gain[c] = lcg_next();
            r = lcg_next();
            tx_in[c] = r[31:16];
        end
        r = lcg_next();
        cpu_x = r[31:16];
        r = lcg_next();
        cpu_y = r[31:16];
        r = lcg_next();
        // strobe on about one cycle in four
        ce_down     = (r[31:30] == 2'b00);
        up_src      = up_src_e'(r[29:28]);
        final_shift = r[27:25];
        dac1_sel    = dac_src_e'(r[24:21]);
        dac2_sel    = dac_src_e'(r[20:17]);
    endtask

    initial begin
        rst         = 1'b1;
        ce_down     = 1'b0;
        cpu_x       = '0;
        cpu_y       = '0;
        up_src      = UP_GAINED;
        final_shift = '0;
        dac1_sel    = SRC_GAIN_Y0;
        dac2_sel    = SRC_GAIN_Y0;
        ls_arm      = 1'b0;
        hs_arm      = 1'b0;
        ls_idx      = '0;
        hs_idx      = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            down_x[c] = '0;
            down_y[c] = '0;
            gain[c]   = '0;
            tx_in[c]  = '0;
        end
        repeat (3) @(negedge sys_clk);
        rst = 1'b0;

        a_rst_done: assert (!o_ls_done && !o_hs_done)
            else report_error("done flags not clear after reset");
        a_rst_out: assert (o_dac1 == '0 && o_dac2 == '0 && o_sum == '0)
            else report_error("dac or sum output not zero after reset");

        // arm then wait for both buffers, read every entry and drop arm
        for (int pass = 0; pass < 3; pass++) begin
            next_cycle();
            ls_arm = 1'b1;
            hs_arm = 1'b1;
            // done of the last pass drops once the arm edge is seen
            while (o_ls_done || o_hs_done) begin
                next_cycle();
            end
            while (!(o_ls_done && o_hs_done)) begin
                next_cycle();
            end
            // idx runs past the depth to hit the ignored upper bits
            for (int i = 0; i < HS_DEPTH + 8; i++) begin
                next_cycle();
                ls_idx = CAP_IDX_W'(i);
                hs_idx = CAP_IDX_W'(i);
            end
            next_cycle();
            ls_arm = 1'b0;
            hs_arm = 1'b0;
        end

        next_cycle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tx_mix_top.f */
source/tx_mix_pkg.sv
source/cap_if.sv
source/channel_gain.sv
source/sum_tree.sv
source/dac_route.sv
source/sample_capture.sv
source/tx_mix_top.sv
testbench/tb_tx_mix_top.sv

/* Makefile */
# Verilator flow for the tx mixing datapath
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= tx_mix_top.f
TB_TOP    ?= tb_tx_mix_top
RTL_TOP   ?= tx_mix_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

# design sources only, taken from the file list
RTL_SRCS := $(filter source/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

# the recipe fails unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
